/* design/lsu_pkg.sv */
// Shared widths and types for the load path; loads must be naturally aligned and stay within one line
package lsu_pkg;

    // Datapath widths
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int TAG_WIDTH  = 6;

    // Cache geometry: 16 sets, 2 ways, 32-byte lines
    localparam int DC_LINE_WIDTH      = 5;
    localparam int DC_INDEX_WIDTH     = 4;
    localparam int DC_WAY_WIDTH       = 1;
    localparam int DC_TAG_WIDTH       = 23;
    localparam int DC_SETS            = 2 ** DC_INDEX_WIDTH;
    localparam int DC_WAYS            = 2 ** DC_WAY_WIDTH;
    localparam int DC_DATA_ADDR_WIDTH = DC_INDEX_WIDTH + DC_WAY_WIDTH + DC_LINE_WIDTH;

    // Line refill is one 32-bit word per beat
    localparam int DC_BEATS      = 8;
    localparam int DC_BEAT_WIDTH = 3;

    // Miss queue
    localparam int MSHQ_DEPTH     = 4;
    localparam int MSHQ_PTR_WIDTH = 2;

    // Head entry states of the miss queue
    localparam logic [1:0] MSHQ_IDLE   = 2'd0;
    localparam logic [1:0] MSHQ_REQ    = 2'd1;
    localparam logic [1:0] MSHQ_FILL   = 2'd2;
    localparam logic [1:0] MSHQ_REPLAY = 2'd3;

    // Load functions, encoded like the RISC-V funct3 field
    typedef enum logic [2:0] {
        LSU_FUNC_LB  = 3'b000,
        LSU_FUNC_LH  = 3'b001,
        LSU_FUNC_LW  = 3'b010,
        LSU_FUNC_LBU = 3'b100,
        LSU_FUNC_LHU = 3'b101
    } lsu_func_t;

    // Load address, seen either flat or split into cache fields
    typedef union packed {
        logic [ADDR_WIDTH-1:0] raw;
        struct packed {
            logic [DC_TAG_WIDTH-1:0]   tag;
            logic [DC_INDEX_WIDTH-1:0] index;
            logic [DC_LINE_WIDTH-1:0]  offset;
        } f;
    } dc_addr_u;

endpackage

/* design/dc_lookup_if.sv */
// Cache lookup signals are all combinational within the memory stage cycle
interface dc_lookup_if import lsu_pkg::*; ();

    // Lookup request from the memory stage
    logic [DC_INDEX_WIDTH-1:0]     index;
    logic [DC_TAG_WIDTH-1:0]       tag;
    logic [DC_DATA_ADDR_WIDTH-1:0] data_addr;

    // Tag compare result
    logic                          hit;
    logic [DC_WAY_WIDTH-1:0]       way;

    // Four bytes starting at data_addr
    logic [DATA_WIDTH-1:0]         data;

    modport lsu (output index, tag, data_addr, input hit, way, data);

    modport tag_side (input index, tag, output hit, way);

    modport data_side (input data_addr, output data);

endinterface

/* design/dc_fill_if.sv */
// One refill word is written on every cycle with valid high; way is picked by the tag array
interface dc_fill_if import lsu_pkg::*; ();

    // Refill beat from the miss queue
    logic                     valid;
    dc_addr_u                 addr;
    logic [DC_BEAT_WIDTH-1:0] beat;
    logic [DATA_WIDTH-1:0]    data;
    logic                     last;

    // Way that receives the line
    logic [DC_WAY_WIDTH-1:0]  way;

    modport mshq (output valid, addr, beat, data, last);

    // Tag side only needs the line address and the closing beat
    modport tag_side (input valid, addr, last, output way);

    modport data_side (input valid, addr, beat, data, way);

endinterface

/* design/lsu_addr.sv */
// Replays take priority over new loads; the stage register has no stall and never holds a load
module lsu_addr import lsu_pkg::*; (
    input  logic                  clk,
    input  logic                  i_rst,

    // New load request
    input  logic                  i_req_valid,
    input  lsu_func_t             i_req_func,
    input  logic [ADDR_WIDTH-1:0] i_req_base,
    input  logic [ADDR_WIDTH-1:0] i_req_offset,
    input  logic [TAG_WIDTH-1:0]  i_req_tag,
    output logic                  o_req_ready,

    // Replay from the miss queue
    input  logic                  i_replay_valid,
    input  lsu_func_t             i_replay_func,
    input  dc_addr_u              i_replay_addr,
    input  logic [TAG_WIDTH-1:0]  i_replay_tag,
    output logic                  o_replay_ack,

    // Miss queue has room for the load in flight plus one more
    input  logic                  i_accept_ok,

    // To the memory stage
    output logic                  o_valid,
    output lsu_func_t             o_func,
    output dc_addr_u              o_addr,
    output logic [TAG_WIDTH-1:0]  o_tag
);

    logic     req_take;
    dc_addr_u req_addr;

    assign o_req_ready  = !i_replay_valid && i_accept_ok;
    assign o_replay_ack = i_replay_valid;
    assign req_take     = i_req_valid && o_req_ready;

    // Effective address of a new load
    assign req_addr.raw = i_req_base + i_req_offset;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_replay_valid || req_take;
        end
    end

    // Payload follows whichever source won this cycle
    always_ff @(posedge clk) begin
        if (i_replay_valid) begin
            o_func <= i_replay_func;
            o_addr <= i_replay_addr;
            o_tag  <= i_replay_tag;
        end else if (req_take) begin
            o_func <= i_req_func;
            o_addr <= req_addr;
            o_tag  <= i_req_tag;
        end
    end

endmodule

/* design/lsu_mem.sv */
// Memory stage has no state; a hit writes back this cycle and a miss enqueues this cycle
module lsu_mem import lsu_pkg::*; (
    // From the address stage
    input  logic                  i_valid,
    input  lsu_func_t             i_func,
    input  dc_addr_u              i_addr,
    input  logic [TAG_WIDTH-1:0]  i_tag,

    // Tag and data lookup
    dc_lookup_if.lsu              lookup,

    // Writeback, no handshake
    output logic                  o_wb_valid,
    output logic [DATA_WIDTH-1:0] o_wb_data,
    output logic [ADDR_WIDTH-1:0] o_wb_addr,
    output logic [TAG_WIDTH-1:0]  o_wb_tag,

    // Missed load to the miss queue
    output logic                  o_mshq_en,
    output lsu_func_t             o_mshq_func,
    output dc_addr_u              o_mshq_addr,
    output logic [TAG_WIDTH-1:0]  o_mshq_tag
);

    // Tag lookup uses the cache fields of the address
    assign lookup.index = i_addr.f.index;
    assign lookup.tag   = i_addr.f.tag;

    // Byte address into the data array, way comes from the tag compare
    assign lookup.data_addr = {i_addr.f.index, lookup.way, i_addr.f.offset};

    // Misses keep the whole load for the replay
    assign o_mshq_en   = i_valid && !lookup.hit;
    assign o_mshq_func = i_func;
    assign o_mshq_addr = i_addr;
    assign o_mshq_tag  = i_tag;

    assign o_wb_valid = i_valid && lookup.hit;
    assign o_wb_addr  = i_addr.raw;
    assign o_wb_tag   = i_tag;

    // Addressed byte sits in bits 7:0 of the returned word
    always_comb begin
        case (i_func)
            LSU_FUNC_LB:  o_wb_data = {{(DATA_WIDTH-8){lookup.data[7]}}, lookup.data[7:0]};
            LSU_FUNC_LH:  o_wb_data = {{(DATA_WIDTH-16){lookup.data[15]}}, lookup.data[15:0]};
            LSU_FUNC_LW:  o_wb_data = lookup.data;
            LSU_FUNC_LBU: o_wb_data = {{(DATA_WIDTH-8){1'b0}}, lookup.data[7:0]};
            LSU_FUNC_LHU: o_wb_data = {{(DATA_WIDTH-16){1'b0}}, lookup.data[15:0]};
            default:      o_wb_data = lookup.data;
        endcase
    end

endmodule

/* design/dc_tag_array.sv */
// Two-way tag store; a fill reuses the way holding its line, else takes the set's victim way
module dc_tag_array import lsu_pkg::*; (
    input  logic          clk,
    input  logic          i_rst,
    dc_lookup_if.tag_side lookup,
    dc_fill_if.tag_side   fill
);

    logic [DC_TAG_WIDTH-1:0] tags [DC_SETS][DC_WAYS];
    logic [DC_WAYS-1:0]      valid [DC_SETS];
    logic [DC_WAY_WIDTH-1:0] victim [DC_SETS];

    logic [DC_INDEX_WIDTH-1:0] fill_index;
    logic                      fill_match;
    logic [DC_WAY_WIDTH-1:0]   match_way;

    // Lookup compare across both ways
    always_comb begin
        lookup.hit = 1'b0;
        lookup.way = '0;
        for (int w = 0; w < DC_WAYS; w++) begin
            if (valid[lookup.index][w] && tags[lookup.index][w] == lookup.tag) begin
                lookup.hit = 1'b1;
                lookup.way = DC_WAY_WIDTH'(w);
            end
        end
    end

    assign fill_index = fill.addr.f.index;

    // Line may already be present when two misses to it were queued
    always_comb begin
        fill_match = 1'b0;
        match_way  = '0;
        for (int w = 0; w < DC_WAYS; w++) begin
            if (valid[fill_index][w] && tags[fill_index][w] == fill.addr.f.tag) begin
                fill_match = 1'b1;
                match_way  = DC_WAY_WIDTH'(w);
            end
        end
    end

    assign fill.way = fill_match ? match_way : victim[fill_index];

    // Evicted line is dropped on its first overwritten beat, new line goes valid on the last
    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int s = 0; s < DC_SETS; s++) begin
                valid[s]  <= '0;
                victim[s] <= '0;
            end
        end else if (fill.valid) begin
            if (fill.last) begin
                valid[fill_index][fill.way] <= 1'b1;
                if (!fill_match) begin
                    victim[fill_index] <= victim[fill_index] + DC_WAY_WIDTH'(1);
                end
            end else if (!fill_match) begin
                valid[fill_index][fill.way] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill.valid && fill.last) begin
            tags[fill_index][fill.way] <= fill.addr.f.tag;
        end
    end

endmodule

/* design/dc_data_array.sv */
// Byte store for both ways; reads past the end of a line return bytes that no load uses
module dc_data_array import lsu_pkg::*; (
    input  logic           clk,
    dc_lookup_if.data_side lookup,
    dc_fill_if.data_side   fill
);

    localparam int BYTES = DATA_WIDTH / 8;

    logic [7:0]                    mem [2 ** DC_DATA_ADDR_WIDTH];
    logic [DC_DATA_ADDR_WIDTH-1:0] fill_base;

    // Little endian, addressed byte first
    always_comb begin
        for (int b = 0; b < BYTES; b++) begin
            lookup.data[8*b +: 8] = mem[lookup.data_addr + DC_DATA_ADDR_WIDTH'(b)];
        end
    end

    // Word position of this beat inside the line
    assign fill_base = {fill.addr.f.index, fill.way, fill.beat,
                        {(DC_LINE_WIDTH-DC_BEAT_WIDTH){1'b0}}};

    always_ff @(posedge clk) begin
        if (fill.valid) begin
            for (int b = 0; b < BYTES; b++) begin
                mem[fill_base + DC_DATA_ADDR_WIDTH'(b)] <= fill.data[8*b +: 8];
            end
        end
    end

endmodule

/* design/mshq.sv */
// In-order miss queue serving one line at a time; memory beats arrive lowest word first, no stall
module mshq import lsu_pkg::*; (
    input  logic                  clk,
    input  logic                  i_rst,

    // Missed load from the memory stage
    input  logic                  i_en,
    input  lsu_func_t             i_func,
    input  dc_addr_u              i_addr,
    input  logic [TAG_WIDTH-1:0]  i_tag,
    output logic                  o_accept_ok,

    // Replay of the head load
    output logic                  o_replay_valid,
    output lsu_func_t             o_replay_func,
    output dc_addr_u              o_replay_addr,
    output logic [TAG_WIDTH-1:0]  o_replay_tag,
    input  logic                  i_replay_ack,

    // External memory
    output logic                  o_mem_req_valid,
    output logic [ADDR_WIDTH-1:0] o_mem_req_addr,
    input  logic                  i_mem_req_ready,
    input  logic                  i_mem_resp_valid,
    input  logic [DATA_WIDTH-1:0] i_mem_resp_data,

    dc_fill_if.mshq               fill
);

    lsu_func_t               q_func [MSHQ_DEPTH];
    dc_addr_u                q_addr [MSHQ_DEPTH];
    logic [TAG_WIDTH-1:0]    q_tag  [MSHQ_DEPTH];

    logic [MSHQ_PTR_WIDTH-1:0] head;
    logic [MSHQ_PTR_WIDTH-1:0] tail;
    logic [MSHQ_PTR_WIDTH:0]   count;
    logic [1:0]                state;
    logic [DC_BEAT_WIDTH-1:0]  beat_cnt;
    logic                      last_beat;
    logic                      pop;
    dc_addr_u                  line_addr;

    // Two free slots cover the load in the memory stage and the one behind it
    assign o_accept_ok = count <= (MSHQ_PTR_WIDTH+1)'(MSHQ_DEPTH - 2);

    always_comb begin
        line_addr          = q_addr[head];
        line_addr.f.offset = '0;
    end

    assign o_mem_req_valid = (state == MSHQ_REQ);
    assign o_mem_req_addr  = line_addr.raw;

    assign last_beat  = (beat_cnt == DC_BEAT_WIDTH'(DC_BEATS - 1));
    assign fill.valid = (state == MSHQ_FILL) && i_mem_resp_valid;
    assign fill.addr  = line_addr;
    assign fill.beat  = beat_cnt;
    assign fill.data  = i_mem_resp_data;
    assign fill.last  = last_beat;

    assign o_replay_valid = (state == MSHQ_REPLAY);
    assign o_replay_func  = q_func[head];
    assign o_replay_addr  = q_addr[head];
    assign o_replay_tag   = q_tag[head];
    assign pop            = o_replay_valid && i_replay_ack;

    always_ff @(posedge clk) begin
        if (i_en) begin
            q_func[tail] <= i_func;
            q_addr[tail] <= i_addr;
            q_tag[tail]  <= i_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            head     <= '0;
            tail     <= '0;
            count    <= '0;
            state    <= MSHQ_IDLE;
            beat_cnt <= '0;
        end else begin
            if (i_en) begin
                tail <= tail + MSHQ_PTR_WIDTH'(1);
            end
            if (pop) begin
                head <= head + MSHQ_PTR_WIDTH'(1);
            end
            count <= count + (MSHQ_PTR_WIDTH+1)'(i_en) - (MSHQ_PTR_WIDTH+1)'(pop);

            case (state)
                MSHQ_IDLE: begin
                    if (count != '0) begin
                        state <= MSHQ_REQ;
                    end
                end
                MSHQ_REQ: begin
                    if (i_mem_req_ready) begin
                        state    <= MSHQ_FILL;
                        beat_cnt <= '0;
                    end
                end
                MSHQ_FILL: begin
                    // Gaps between beats just hold the counter
                    if (i_mem_resp_valid) begin
                        beat_cnt <= beat_cnt + DC_BEAT_WIDTH'(1);
                        if (last_beat) begin
                            state <= MSHQ_REPLAY;
                        end
                    end
                end
                default: begin
                    if (i_replay_ack) begin
                        state <= MSHQ_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

/* design/lsu_top.sv */
// Load-only path; writeback has no ready, so results may leave out of order
module lsu_top import lsu_pkg::*; (
    input  logic                  clk,
    input  logic                  i_rst,

    // Load requests
    input  logic                  i_req_valid,
    input  lsu_func_t             i_req_func,
    input  logic [ADDR_WIDTH-1:0] i_req_base,
    input  logic [ADDR_WIDTH-1:0] i_req_offset,
    input  logic [TAG_WIDTH-1:0]  i_req_tag,
    output logic                  o_req_ready,

    // Writeback
    output logic                  o_wb_valid,
    output logic [DATA_WIDTH-1:0] o_wb_data,
    output logic [ADDR_WIDTH-1:0] o_wb_addr,
    output logic [TAG_WIDTH-1:0]  o_wb_tag,

    // External memory
    output logic                  o_mem_req_valid,
    output logic [ADDR_WIDTH-1:0] o_mem_req_addr,
    input  logic                  i_mem_req_ready,
    input  logic                  i_mem_resp_valid,
    input  logic [DATA_WIDTH-1:0] i_mem_resp_data
);

    dc_lookup_if dc_lookup ();
    dc_fill_if   dc_fill ();

    // Address stage to memory stage
    logic                 mem_valid;
    lsu_func_t            mem_func;
    dc_addr_u             mem_addr;
    logic [TAG_WIDTH-1:0] mem_tag;

    // Memory stage to miss queue
    logic                 mshq_en;
    lsu_func_t            mshq_func;
    dc_addr_u             mshq_addr;
    logic [TAG_WIDTH-1:0] mshq_tag;
    logic                 accept_ok;

    // Miss queue replay
    logic                 replay_valid;
    lsu_func_t            replay_func;
    dc_addr_u             replay_addr;
    logic [TAG_WIDTH-1:0] replay_tag;
    logic                 replay_ack;

    lsu_addr u_addr (
        .clk, .i_rst,
        .i_req_valid, .i_req_func, .i_req_base, .i_req_offset, .i_req_tag, .o_req_ready,
        .i_replay_valid (replay_valid), .i_replay_func (replay_func),
        .i_replay_addr  (replay_addr),  .i_replay_tag  (replay_tag),
        .o_replay_ack   (replay_ack),   .i_accept_ok   (accept_ok),
        .o_valid (mem_valid), .o_func (mem_func), .o_addr (mem_addr), .o_tag (mem_tag)
    );

    lsu_mem u_mem (
        .i_valid (mem_valid), .i_func (mem_func), .i_addr (mem_addr), .i_tag (mem_tag),
        .lookup  (dc_lookup),
        .o_wb_valid, .o_wb_data, .o_wb_addr, .o_wb_tag,
        .o_mshq_en   (mshq_en),   .o_mshq_func (mshq_func),
        .o_mshq_addr (mshq_addr), .o_mshq_tag  (mshq_tag)
    );

    dc_tag_array u_tags (.clk, .i_rst, .lookup (dc_lookup), .fill (dc_fill));

    dc_data_array u_data (.clk, .lookup (dc_lookup), .fill (dc_fill));

    mshq u_mshq (
        .clk, .i_rst,
        .i_en (mshq_en), .i_func (mshq_func), .i_addr (mshq_addr), .i_tag (mshq_tag),
        .o_accept_ok    (accept_ok),
        .o_replay_valid (replay_valid), .o_replay_func (replay_func),
        .o_replay_addr  (replay_addr),  .o_replay_tag  (replay_tag),
        .i_replay_ack   (replay_ack),
        .o_mem_req_valid, .o_mem_req_addr, .i_mem_req_ready,
        .i_mem_resp_valid, .i_mem_resp_data,
        .fill (dc_fill)
    );

endmodule

/* dv/lsu_mem_model.sv */
// Line memory responder; one request at a time, eight beats lowest word first, data hashed per word
module lsu_mem_model import lsu_pkg::*; (
    input  logic                  clk,
    input  logic                  i_rst,
    input  logic [31:0]           i_rand,
    input  logic                  i_req_valid,
    input  logic [ADDR_WIDTH-1:0] i_req_addr,
    output logic                  o_req_ready,
    output logic                  o_resp_valid,
    output logic [DATA_WIDTH-1:0] o_resp_data
);

    logic                     busy;
    logic [ADDR_WIDTH-1:0]    line;
    logic [DC_BEAT_WIDTH-1:0] beat;

    // Word contents depend on every address bit
    function automatic logic [31:0] word_hash(input logic [31:0] addr);
        logic [31:0] h;
        h = addr * 32'h9e3779b1;
        return h ^ (h >> 15) ^ 32'h5bd1e995;
    endfunction

    initial begin
        o_req_ready  = 1'b0;
        o_resp_valid = 1'b0;
        o_resp_data  = '0;
    end

    always @(posedge clk) begin
        if (i_rst) begin
            o_req_ready  <= 1'b0;
            o_resp_valid <= 1'b0;
            busy         <= 1'b0;
            beat         <= '0;
        end else begin
            // Ready toggles at random, beats come with random gaps
            o_req_ready  <= i_rand[31];
            o_resp_valid <= 1'b0;
            if (!busy && i_req_valid && o_req_ready) begin
                busy <= 1'b1;
                line <= i_req_addr;
                beat <= '0;
            end else if (busy && i_rand[30:29] != 2'b00) begin
                o_resp_valid <= 1'b1;
                o_resp_data  <= word_hash(line + {beat, 2'b00});
                beat         <= beat + 1'b1;
                if (beat == DC_BEAT_WIDTH'(DC_BEATS - 1)) begin
                    busy <= 1'b0;
                end
            end
        end
    end

endmodule

/* dv/lsu_tb.sv */
// Load testbench over 8 lines in 3 sets; expected data comes from the memory word hash
module lsu_tb import lsu_pkg::*; ();

    localparam logic [31:0] SEED       = 32'hf2fd9dc1;
    localparam int          WAIT_LIMIT = 2000;
    localparam int          NUM_LOADS  = 400;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 req_valid, req_ready;
    lsu_func_t            req_func;
    logic [31:0]          req_base, req_offset;
    logic [TAG_WIDTH-1:0] req_tag;
    logic                 wb_valid;
    logic [31:0]          wb_data, wb_addr;
    logic [TAG_WIDTH-1:0] wb_tag;
    logic                 mem_req_valid, mem_req_ready, mem_resp_valid;
    logic [31:0]          mem_req_addr, mem_resp_data, mem_rand;

    // Reference model state indexed by load tag
    logic [31:0]          exp_addr [64];
    lsu_func_t            exp_func [64];
    int                   accept_cyc [64];
    bit                   outstanding [64];
    bit                   expect_hit [64];
    logic [TAG_WIDTH-1:0] free_tags [$];

    lsu_func_t func_list [5] = '{LSU_FUNC_LB, LSU_FUNC_LH, LSU_FUNC_LW, LSU_FUNC_LBU, LSU_FUNC_LHU};
    logic [31:0] stim_state = SEED;
    logic [31:0] mem_state = ~SEED;
    logic [31:0] fill_line, resident_line;
    bit          resident_ok = 1'b0;
    bit          fill_seen = 1'b0;
    bit          timed_out = 1'b0;
    int          value_errors = 0;
    int          other_errors = 0;
    int          cyc = 0;
    int          n_out = 0;
    int          ready_low = 0;
    int          hit_checks = 0;
    int          beats = 0;

    always #20 clk = ~clk;

    lsu_top dut0 (
        .clk, .i_rst (rst),
        .i_req_valid (req_valid), .i_req_func (req_func), .i_req_base (req_base),
        .i_req_offset (req_offset), .i_req_tag (req_tag), .o_req_ready (req_ready),
        .o_wb_valid (wb_valid), .o_wb_data (wb_data), .o_wb_addr (wb_addr), .o_wb_tag (wb_tag),
        .o_mem_req_valid (mem_req_valid), .o_mem_req_addr (mem_req_addr),
        .i_mem_req_ready (mem_req_ready), .i_mem_resp_valid (mem_resp_valid),
        .i_mem_resp_data (mem_resp_data)
    );

    lsu_mem_model mem0 (
        .clk, .i_rst (rst), .i_rand (mem_rand),
        .i_req_valid (mem_req_valid), .i_req_addr (mem_req_addr), .o_req_ready (mem_req_ready),
        .o_resp_valid (mem_resp_valid), .o_resp_data (mem_resp_data)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function logic [31:0] next_rand();
        stim_state = lcg_next(stim_state);
        return stim_state;
    endfunction

    function automatic logic [31:0] line_of(input logic [31:0] a);
        return {a[31:5], 5'b00000};
    endfunction

    // Lines in sets 1, 3 and 5 with up to three tags each
    function automatic logic [31:0] test_line(input logic [2:0] k);
        return 32'h4000_0000 + (int'(k) / 3) * 32'h200 + ((int'(k) % 3) * 2 + 1) * 32'h20;
    endfunction

    function automatic logic [4:0] aligned_offset(input lsu_func_t f, input logic [4:0] r);
        case (f)
            LSU_FUNC_LW:               return {r[4:2], 2'b00};
            LSU_FUNC_LH, LSU_FUNC_LHU: return {r[4:1], 1'b0};
            default:                   return r;
        endcase
    endfunction

    // Memory is little endian and all halfwords and words are aligned
    function automatic logic [31:0] load_result(input lsu_func_t f, input logic [31:0] a);
        logic [31:0] w;
        w = mem0.word_hash({a[31:2], 2'b00}) >> (8 * a[1:0]);
        case (f)
            LSU_FUNC_LB:  return {{24{w[7]}}, w[7:0]};
            LSU_FUNC_LH:  return {{16{w[15]}}, w[15:0]};
            LSU_FUNC_LBU: return {24'b0, w[7:0]};
            LSU_FUNC_LHU: return {16'b0, w[15:0]};
            default:      return w;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            value_errors++;
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timeout after %0d cycles: %s", WAIT_LIMIT, what);
        other_errors++;
        timed_out = 1'b1;
    endtask

    task automatic check_idle();
        check_value("o_wb_valid", 0, wb_valid);
        check_value("o_mem_req_valid", 0, mem_req_valid);
        check_value("o_req_ready", 1, req_ready);
    endtask

    task automatic send_load(input lsu_func_t f, input logic [31:0] addr);
        logic [31:0]          disp;
        logic [TAG_WIDTH-1:0] tag;
        int                   waited;
        if (timed_out) return;
        waited = 0;
        while (free_tags.size() == 0 && waited < WAIT_LIMIT) begin
            req_valid <= 1'b0;
            @(posedge clk);
            waited++;
        end
        if (free_tags.size() == 0) begin
            stop_on_timeout("no free load tag");
            return;
        end
        tag  = free_tags.pop_front();
        disp = next_rand();
        // Sign-extended displacement so the adder sees both directions
        disp = {{20{disp[31]}}, disp[31:20]};
        req_valid  <= 1'b1;
        req_func   <= f;
        req_base   <= addr - disp;
        req_offset <= disp;
        req_tag    <= tag;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!req_ready && waited < WAIT_LIMIT);
        if (!req_ready) stop_on_timeout("load request was never accepted");
    endtask

    task automatic idle_cycles(input int n);
        if (timed_out) return;
        req_valid <= 1'b0;
        repeat (n) @(posedge clk);
    endtask

    task automatic drain();
        int waited;
        if (timed_out) return;
        req_valid <= 1'b0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (n_out != 0 && waited < WAIT_LIMIT);
        if (n_out != 0) stop_on_timeout("outstanding loads did not drain");
        @(posedge clk);
    endtask

    task automatic random_loads(input int n);
        logic [31:0] r;
        lsu_func_t   f;
        for (int i = 0; i < n; i++) begin
            if (timed_out) break;
            r = next_rand();
            f = func_list[r[31:29] % 5];
            send_load(f, test_line(r[28:26]) + {27'b0, aligned_offset(f, r[25:21])});
            // Mostly back to back so misses come in bursts
            if (r[20:18] == 3'd0) idle_cycles(int'(r[17:15]) + 1);
        end
    endtask

    always @(posedge clk) begin
        mem_state = lcg_next(mem_state);
        mem_rand <= mem_state;
    end

    always @(posedge clk) begin : monitor
        bit found;
        cyc++;
        if (!rst) begin
            // With a line request waiting no replay is pending and low ready means a full queue
            if (!req_ready && mem_req_valid) ready_low++;
            if (req_valid && req_ready) begin
                if (outstanding[req_tag]) begin
                    $display("Tag %0d was accepted while still outstanding", req_tag);
                    other_errors++;
                end
                outstanding[req_tag] = 1'b1;
                exp_func[req_tag]    = req_func;
                exp_addr[req_tag]    = req_base + req_offset;
                accept_cyc[req_tag]  = cyc;
                // No fill has started since this line was filled so it must hit
                expect_hit[req_tag] = resident_ok && line_of(exp_addr[req_tag]) == resident_line;
                n_out++;
            end
            if (wb_valid) begin
                if (!outstanding[wb_tag]) begin
                    $display("Writeback of tag %0d, which is not outstanding", wb_tag);
                    other_errors++;
                end else begin
                    check_value("o_wb_addr", exp_addr[wb_tag], wb_addr);
                    check_value("o_wb_data", load_result(exp_func[wb_tag], exp_addr[wb_tag]),
                                wb_data);
                    if (expect_hit[wb_tag]) begin
                        check_value("o_wb_valid cycle", accept_cyc[wb_tag] + 1, cyc);
                        hit_checks++;
                    end
                    outstanding[wb_tag] = 1'b0;
                    free_tags.push_back(wb_tag);
                    n_out--;
                end
            end
            if (mem_req_valid && mem_req_ready) begin
                check_value("o_mem_req_addr[4:0]", 0, mem_req_addr & 32'h1f);
                found = 1'b0;
                for (int t = 0; t < 64; t++) begin
                    if (outstanding[t] && line_of(exp_addr[t]) == mem_req_addr) found = 1'b1;
                end
                if (!found) begin
                    $display("Memory request for line %h with no outstanding load", mem_req_addr);
                    other_errors++;
                end
                if (fill_seen) check_value("beats per line", DC_BEATS, beats);
                fill_seen   = 1'b1;
                fill_line   = mem_req_addr;
                beats       = 0;
                resident_ok = 1'b0;
            end
            if (mem_resp_valid) begin
                beats++;
                if (beats == DC_BEATS) begin
                    resident_ok   = 1'b1;
                    resident_line = fill_line;
                end
            end
        end
    end

    initial begin : main
        rst        = 1'b1;
        req_valid  = 1'b0;
        req_func   = LSU_FUNC_LW;
        req_base   = '0;
        req_offset = '0;
        req_tag    = '0;
        mem_rand   = '0;
        for (int t = 0; t < 64; t++) free_tags.push_back(TAG_WIDTH'(t));
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            if (i > 0) check_idle();
        end
        rst <= 1'b0;
        @(posedge clk);
        check_idle();

        random_loads(NUM_LOADS);
        drain();

        // Fresh line and then a second load to it after the replay is done
        send_load(LSU_FUNC_LW, 32'h5000_0028);
        drain();
        send_load(LSU_FUNC_LH, 32'h5000_0036);
        drain();

        if (!timed_out && hit_checks == 0) begin
            $display("No load to an already filled line was checked for hit timing");
            other_errors++;
        end
        if (!timed_out && ready_low == 0) begin
            $display("o_req_ready never dropped for a nearly full miss queue");
            other_errors++;
        end
        if (!timed_out && fill_seen) check_value("beats per line", DC_BEATS, beats);

        $display("Checks done: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* project.f */
design/lsu_pkg.sv
design/dc_lookup_if.sv
design/dc_fill_if.sv
design/lsu_addr.sv
design/lsu_mem.sv
design/dc_tag_array.sv
design/dc_data_array.sv
design/mshq.sv
design/lsu_top.sv
dv/lsu_mem_model.sv
dv/lsu_tb.sv
